/* common/mmu_config.svh */
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// TLB depth, any value from 2 to 16 works
`define MMU_TLB_ENTRIES 4

// Region table size, indexed by top address bits
`define MMU_REGIONS 8

// 4 KB pages
`define MMU_PAGE_SHIFT 12

// APB register map, byte offsets
`define MMU_REG_STAGE_VPN 8'h00
`define MMU_REG_STAGE_PPN 8'h04
`define MMU_REG_COMMIT 8'h08
`define MMU_REG_FLUSH 8'h0C
// First region register, the rest follow at a stride of 4
`define MMU_REG_REGION0 8'h10

`endif

/* common/mmu_pkg.sv */
`default_nettype none
`include "mmu_config.svh"

package mmu_pkg;

	// Address and page number widths
	typedef logic [31:0] vaddr_t;
	typedef logic [31:0] paddr_t;
	typedef logic [19:0] vpn_t;
	typedef logic [19:0] ppn_t;

	// Access rights, read / write / execute
	typedef logic [2:0] rwx_t;
	localparam int RWX_R = 2;
	localparam int RWX_W = 1;
	localparam int RWX_X = 0;

	// Operating mode of the access
	typedef logic [1:0] op_mode_t;
	localparam op_mode_t OM_USER = 2'd0;
	localparam op_mode_t OM_SUPER = 2'd1;
	localparam op_mode_t OM_HYPER = 2'd2;
	localparam op_mode_t OM_MACHINE = 2'd3;

	// TLB slot and region table indices
	typedef logic [$clog2(`MMU_TLB_ENTRIES)-1:0] tlb_idx_t;
	typedef logic [$clog2(`MMU_REGIONS)-1:0] region_idx_t;

	// One TLB entry
	typedef struct packed {
		logic valid;
		vpn_t vpn;
		ppn_t ppn;
		logic u;
		rwx_t rwx;
	} tlb_entry_t;

	// One region, an attribute set per operating mode
	// at[0] sits in bits 2:0, at[3] in bits 11:9
	typedef struct packed {
		rwx_t [3:0] at;
	} region_t;

	// APB bus phase
	typedef enum logic [1:0] {APB_IDLE, APB_SETUP, APB_ACCESS} apb_state_t;

endpackage

`default_nettype wire

/* common/tlb_fill_if.sv */
`timescale 1ns/10ps
`default_nettype none

// TLB fill and flush path from the register block to the entries
interface tlb_fill_if;

	// One-cycle write strobe
	logic wr_en;

	// Target slot of the write
	mmu_pkg::tlb_idx_t wr_idx;

	// Entry contents, valid bit set by the source
	mmu_pkg::tlb_entry_t wr_entry;

	// One-cycle flush, clears every valid bit
	logic flush;

	// APB register block side
	modport src
	(
		output wr_en,
		output wr_idx,
		output wr_entry,
		output flush
	);

	// TLB entry side
	modport dst
	(
		input wr_en,
		input wr_idx,
		input wr_entry,
		input flush
	);

endinterface

`default_nettype wire

/* hdl/mmu_attr_check.sv */
`timescale 1ns/10ps
`default_nettype none

module mmu_attr_check
(
	// Instruction fetch when high, data access when low
	input wire logic id,
	input wire mmu_pkg::op_mode_t om,
	input wire logic we,
	input wire mmu_pkg::tlb_entry_t entry,
	input wire mmu_pkg::region_t region,
	output logic priv_err
);

	mmu_pkg::rwx_t reg_rwx;
	logic fetch_wr;

	// True when the attribute set lacks the right this access needs
	function automatic logic lacks_right(mmu_pkg::rwx_t rwx, logic fetch, logic wr);
		logic bad;
		bad = 1'b0;
		// Write needs W
		if (wr && !rwx[mmu_pkg::RWX_W])
			bad = 1'b1;
		// Fetch needs X
		if (fetch && !rwx[mmu_pkg::RWX_X])
			bad = 1'b1;
		// Data read needs R
		if (!fetch && !wr && !rwx[mmu_pkg::RWX_R])
			bad = 1'b1;
		return bad;
	endfunction

	// Region attributes for the current mode
	assign reg_rwx = region.at[om];

	// Never legal outside machine mode
	assign fetch_wr = id && we;

	always_comb
	begin
		priv_err = 1'b0;
		case (om)
			mmu_pkg::OM_USER, mmu_pkg::OM_SUPER:
			begin
				if (fetch_wr)
					priv_err = 1'b1;
				// Region table check
				if (lacks_right(reg_rwx, id, we))
					priv_err = 1'b1;
				// TLB page check
				if (lacks_right(entry.rwx, id, we))
					priv_err = 1'b1;
				// User code only touches user pages
				if ((om == mmu_pkg::OM_USER) && !entry.u)
					priv_err = 1'b1;
			end
			mmu_pkg::OM_HYPER:
			begin
				if (fetch_wr)
					priv_err = 1'b1;
				// Only write protection from the region table
				if (we && !reg_rwx[mmu_pkg::RWX_W])
					priv_err = 1'b1;
			end
			default:
			begin
				// Machine mode, region write protection only
				if (we && !reg_rwx[mmu_pkg::RWX_W])
					priv_err = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

/* tlb/tlb_entry_slot.sv */
`timescale 1ns/10ps
`default_nettype none

module tlb_entry_slot
#(
	// Slot number, matched against the fill index
	parameter int IDX = 0
)
(
	input wire logic clk,
	input wire logic rst_n,
	tlb_fill_if.dst fill,
	input wire mmu_pkg::vpn_t lookup_vpn,
	output logic hit,
	output mmu_pkg::tlb_entry_t entry
);

	logic valid_q;
	mmu_pkg::vpn_t vpn_q;
	mmu_pkg::ppn_t ppn_q;
	logic u_q;
	mmu_pkg::rwx_t rwx_q;
	logic load;

	// Fill aimed at this slot
	assign load = fill.wr_en && (fill.wr_idx == mmu_pkg::tlb_idx_t'(IDX));

	// Valid bit, flush wins
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			valid_q <= 1'b0;
		else if (fill.flush)
			valid_q <= 1'b0;
		else if (load)
			valid_q <= fill.wr_entry.valid;
	end

	// Entry payload
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			vpn_q <= fill.wr_entry.vpn;
			ppn_q <= fill.wr_entry.ppn;
			u_q <= fill.wr_entry.u;
			rwx_q <= fill.wr_entry.rwx;
		end
	end

	// Fully associative compare
	assign hit = valid_q && (vpn_q == lookup_vpn);

	assign entry = '{valid: valid_q, vpn: vpn_q, ppn: ppn_q, u: u_q, rwx: rwx_q};

endmodule

`default_nettype wire

/* tlb/tlb_hit_select.sv */
`timescale 1ns/10ps
`default_nettype none
`include "mmu_config.svh"

module tlb_hit_select
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic req_valid,
	input wire mmu_pkg::vaddr_t vaddr,
	input wire mmu_pkg::op_mode_t om,
	input wire logic id,
	input wire logic we,
	input wire logic [`MMU_TLB_ENTRIES-1:0] hits,
	input wire mmu_pkg::tlb_entry_t entries [`MMU_TLB_ENTRIES],
	input wire mmu_pkg::region_t regions [`MMU_REGIONS],
	output logic rsp_valid,
	output mmu_pkg::paddr_t paddr,
	output logic miss,
	output logic priv_err
);

	mmu_pkg::tlb_entry_t sel_entry;
	mmu_pkg::region_idx_t region_idx;
	mmu_pkg::region_t sel_region;
	mmu_pkg::paddr_t xlate_pa;
	logic any_hit;
	logic chk_err;

	// Lowest index wins, so scan downwards
	always_comb
	begin
		sel_entry = '0;
		for (int i = `MMU_TLB_ENTRIES - 1; i >= 0; i--)
		begin
			if (hits[i])
				sel_entry = entries[i];
		end
	end

	assign any_hit = |hits;

	// Region from the top address bits
	assign region_idx = vaddr[31 -: $bits(mmu_pkg::region_idx_t)];
	assign sel_region = regions[region_idx];

	// Page frame plus offset
	assign xlate_pa = {sel_entry.ppn, vaddr[`MMU_PAGE_SHIFT-1:0]};

	mmu_attr_check attr_i
	(
		.id(id),
		.om(om),
		.we(we),
		.entry(sel_entry),
		.region(sel_region),
		.priv_err(chk_err)
	);

	// Response flags, one cycle per request
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rsp_valid <= 1'b0;
			miss <= 1'b0;
			priv_err <= 1'b0;
		end
		else
		begin
			rsp_valid <= req_valid;
			miss <= req_valid && !any_hit;
			// A miss never reports a privilege error
			priv_err <= req_valid && any_hit && chk_err;
		end
	end

	// Physical address, zero on a miss
	always_ff @(posedge clk)
	begin
		if (req_valid)
			paddr <= any_hit ? xlate_pa : '0;
	end

endmodule

`default_nettype wire

/* hdl/mmu_apb_regs.sv */
`timescale 1ns/10ps
`default_nettype none
`include "mmu_config.svh"

module mmu_apb_regs
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [7:0] paddr,
	input wire logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	tlb_fill_if.src fill,
	output mmu_pkg::region_t regions [`MMU_REGIONS]
);

	mmu_pkg::apb_state_t state_q;
	logic access;
	logic wr_ok;
	logic in_map;
	logic is_region;
	logic [7:0] region_off;
	mmu_pkg::region_idx_t region_idx;

	// Staging registers for the next TLB commit
	mmu_pkg::vpn_t stage_vpn_q;
	mmu_pkg::ppn_t stage_ppn_q;
	logic stage_u_q;
	mmu_pkg::rwx_t stage_rwx_q;

	// Phase tracking, an access only counts after a setup cycle
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state_q <= mmu_pkg::APB_IDLE;
		else if (psel && !penable)
			state_q <= mmu_pkg::APB_SETUP;
		else if (access)
			state_q <= mmu_pkg::APB_ACCESS;
		else
			state_q <= mmu_pkg::APB_IDLE;
	end

	assign access = psel && penable && (state_q == mmu_pkg::APB_SETUP);
	assign wr_ok = access && pwrite && in_map;

	// Region window decode
	assign region_off = paddr - `MMU_REG_REGION0;
	assign region_idx = region_off[2 +: $bits(mmu_pkg::region_idx_t)];
	assign is_region = (paddr >= `MMU_REG_REGION0) && (paddr[1:0] == 2'b00)
		&& (region_off < 8'(4 * `MMU_REGIONS));

	always_comb
	begin
		case (paddr)
			`MMU_REG_STAGE_VPN, `MMU_REG_STAGE_PPN, `MMU_REG_COMMIT, `MMU_REG_FLUSH:
				in_map = 1'b1;
			default:
				in_map = is_region;
		endcase
	end

	// No wait states
	assign pready = 1'b1;
	assign pslverr = access && !in_map;

	// Read mux, commit and flush read back as zero
	always_comb
	begin
		prdata = '0;
		case (paddr)
			`MMU_REG_STAGE_VPN:
				prdata = {stage_vpn_q, {`MMU_PAGE_SHIFT{1'b0}}};
			`MMU_REG_STAGE_PPN:
				prdata = {stage_ppn_q, 8'h00, stage_u_q, stage_rwx_q};
			default:
				if (is_region)
					prdata = 32'(regions[region_idx]);
		endcase
	end

	// Staging and region registers
	// Page numbers sit in 31:12, u in bit 3, rwx in 2:0
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			stage_vpn_q <= '0;
			stage_ppn_q <= '0;
			stage_u_q <= 1'b0;
			stage_rwx_q <= '0;
			// Permissive until software says otherwise
			for (int i = 0; i < `MMU_REGIONS; i++)
				regions[i] <= 12'hFFF;
		end
		else if (wr_ok)
		begin
			case (paddr)
				`MMU_REG_STAGE_VPN:
					stage_vpn_q <= pwdata[31:`MMU_PAGE_SHIFT];
				`MMU_REG_STAGE_PPN:
				begin
					stage_ppn_q <= pwdata[31:`MMU_PAGE_SHIFT];
					stage_u_q <= pwdata[3];
					stage_rwx_q <= pwdata[2:0];
				end
				default:
					if (is_region)
						regions[region_idx] <= mmu_pkg::region_t'(pwdata[11:0]);
			endcase
		end
	end

	// Fill and flush strobes, one cycle after the access phase
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			fill.wr_en <= 1'b0;
			fill.flush <= 1'b0;
		end
		else
		begin
			fill.wr_en <= wr_ok && (paddr == `MMU_REG_COMMIT);
			fill.flush <= wr_ok && (paddr == `MMU_REG_FLUSH);
		end
	end

	// Commit payload, the written value picks the slot
	always_ff @(posedge clk)
	begin
		if (wr_ok && (paddr == `MMU_REG_COMMIT))
		begin
			fill.wr_idx <= mmu_pkg::tlb_idx_t'(pwdata);
			fill.wr_entry <= '{valid: 1'b1, vpn: stage_vpn_q, ppn: stage_ppn_q,
				u: stage_u_q, rwx: stage_rwx_q};
		end
	end

endmodule

`default_nettype wire

/* hdl/mmu_xlate_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "mmu_config.svh"

module mmu_xlate_top
(
	input wire logic clk,
	input wire logic rst_n,
	// APB configuration port
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [7:0] paddr,
	input wire logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	// Lookup request, one per cycle
	input wire logic req_valid,
	input wire mmu_pkg::vaddr_t vaddr,
	input wire mmu_pkg::op_mode_t om,
	input wire logic id,
	input wire logic we,
	// Registered response
	output logic rsp_valid,
	output mmu_pkg::paddr_t rsp_paddr,
	output logic miss,
	output logic priv_err
);

	tlb_fill_if fill_bus ();

	logic [`MMU_TLB_ENTRIES-1:0] hits;
	mmu_pkg::tlb_entry_t entries [`MMU_TLB_ENTRIES];
	mmu_pkg::region_t regions [`MMU_REGIONS];

	// Configuration registers and region table
	mmu_apb_regs regs_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.fill(fill_bus),
		.regions(regions)
	);

	// TLB entries, all compare against the lookup page
	genvar g;
	for (g = 0; g < `MMU_TLB_ENTRIES; g++)
	begin : g_slot
		tlb_entry_slot #(.IDX(g)) slot_i
		(
			.clk(clk),
			.rst_n(rst_n),
			.fill(fill_bus),
			.lookup_vpn(vaddr[31:`MMU_PAGE_SHIFT]),
			.hit(hits[g]),
			.entry(entries[g])
		);
	end

	// Priority select, check and response register
	tlb_hit_select sel_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.vaddr(vaddr),
		.om(om),
		.id(id),
		.we(we),
		.hits(hits),
		.entries(entries),
		.regions(regions),
		.rsp_valid(rsp_valid),
		.paddr(rsp_paddr),
		.miss(miss),
		.priv_err(priv_err)
	);

endmodule

`default_nettype wire

/* tests/mmu_xlate_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "mmu_config.svh"

module mmu_xlate_tb;

	// About three times the 720 cycles the tests take
	localparam int TIMEOUT_CYCLES = 2000;

	logic clk;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic req_valid;
	mmu_pkg::vaddr_t vaddr;
	mmu_pkg::op_mode_t om;
	logic id;
	logic we;
	logic rsp_valid;
	mmu_pkg::paddr_t rsp_paddr;
	logic miss;
	logic priv_err;

	// Bus phase as seen by the APB tasks
	mmu_pkg::apb_state_t apb_phase;
	logic apb_err;
	logic [31:0] rnd;
	int errors;
	int tests;
	int failed_tests;
	int cycles;

	mmu_xlate_top dut_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.req_valid(req_valid),
		.vaddr(vaddr),
		.om(om),
		.id(id),
		.we(we),
		.rsp_valid(rsp_valid),
		.rsp_paddr(rsp_paddr),
		.miss(miss),
		.priv_err(priv_err)
	);

	// 8 ns clock
	always #4 clk = ~clk;

	// Watchdog
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles == TIMEOUT_CYCLES)
		begin
			$display("Run timed out after %0d cycles in APB phase %s", cycles,
				apb_phase.name());
			$display("Errors found");
			$finish;
		end
	end

	// Numerical Recipes LCG constants
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Expected privilege error for one access
	function automatic logic priv_model(input logic [1:0] m, input logic f, input logic w,
		input logic [2:0] pg, input logic pu, input logic [11:0] rg);
		logic [2:0] ra;
		logic [2:0] need;
		logic err;
		ra = rg[3 * int'(m) +: 3];
		// Needed rights in read write execute order
		need = {!f && !w, w, f};
		err = 1'b0;
		if (m == 2'd0 || m == 2'd1)
		begin
			err = (f && w) || ((need & ~ra) != 3'b000) || ((need & ~pg) != 3'b000);
			// User mode also needs a user page
			if (m == 2'd0 && !pu)
				err = 1'b1;
		end
		else if (m == 2'd2)
			err = (f && w) || (w && !ra[1]);
		else
			err = w && !ra[1];
		return err;
	endfunction

	task automatic report_mismatch(input string sig, input logic [31:0] exp,
		input logic [31:0] act);
		$display("Fail %s: expected 0x%h, got 0x%h", sig, exp, act);
		errors++;
	endtask

	// Two-cycle write between falling edges
	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		apb_phase = mmu_pkg::APB_SETUP;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		apb_phase = mmu_pkg::APB_ACCESS;
		penable = 1'b1;
		// Mid-cycle sample of the access phase
		#2;
		apb_err = pslverr;
		// No wait states
		if (pready !== 1'b1)
			report_mismatch("pready", 32'h1, 32'(pready));
		@(negedge clk);
		apb_phase = mmu_pkg::APB_IDLE;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		apb_phase = mmu_pkg::APB_SETUP;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk);
		apb_phase = mmu_pkg::APB_ACCESS;
		penable = 1'b1;
		#2;
		data = prdata;
		apb_err = pslverr;
		if (pready !== 1'b1)
			report_mismatch("pready", 32'h1, 32'(pready));
		@(negedge clk);
		apb_phase = mmu_pkg::APB_IDLE;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	// Stage and commit one TLB entry
	task automatic tlb_fill(input int idx, input mmu_pkg::vpn_t vpn, input mmu_pkg::ppn_t ppn,
		input logic u, input mmu_pkg::rwx_t rwx);
		apb_write(`MMU_REG_STAGE_VPN, {vpn, 12'h000});
		apb_write(`MMU_REG_STAGE_PPN, {ppn, 8'h00, u, rwx});
		apb_write(`MMU_REG_COMMIT, idx);
		// Fill strobe reaches the slot one cycle later
		@(negedge clk);
	endtask

	task automatic tlb_flush();
		apb_write(`MMU_REG_FLUSH, 32'h0);
		@(negedge clk);
	endtask

	task automatic drive_req(input logic v, input mmu_pkg::vaddr_t va,
		input mmu_pkg::op_mode_t m, input logic f, input logic w);
		req_valid = v;
		vaddr = va;
		om = m;
		id = f;
		we = w;
	endtask

	// Single request with the response readable on return
	task automatic lookup(input mmu_pkg::vaddr_t va, input mmu_pkg::op_mode_t m,
		input logic f, input logic w);
		drive_req(1'b1, va, m, f, w);
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic check_xlate(input logic exp_miss, input mmu_pkg::paddr_t exp_pa);
		if (rsp_valid !== 1'b1)
			report_mismatch("rsp_valid", 32'h1, 32'(rsp_valid));
		if (miss !== exp_miss)
			report_mismatch("miss", 32'(exp_miss), 32'(miss));
		if (rsp_paddr !== exp_pa)
			report_mismatch("rsp_paddr", exp_pa, rsp_paddr);
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests++;
		if (errors == errs_before)
			$display("%s: ok", name);
		else
		begin
			failed_tests++;
			$display("%s: %0d mismatches", name, errors - errs_before);
		end
	endtask

	task automatic reset_defaults();
		int errs;
		logic [31:0] data;
		errs = errors;
		// Nothing may come out of an idle cycle
		@(negedge clk);
		if (rsp_valid !== 1'b0)
			report_mismatch("rsp_valid", 32'h0, 32'(rsp_valid));
		lookup(32'h0000_1234, mmu_pkg::OM_MACHINE, 1'b0, 1'b0);
		check_xlate(1'b1, 32'h0);
		if (priv_err !== 1'b0)
			report_mismatch("priv_err", 32'h0, 32'(priv_err));
		// Regions come up permissive
		for (int r = 0; r < `MMU_REGIONS; r++)
		begin
			apb_read(`MMU_REG_REGION0 + 8'(4 * r), data);
			if (data !== 32'h0000_0FFF)
				report_mismatch("prdata", 32'h0000_0FFF, data);
		end
		apb_read(`MMU_REG_STAGE_VPN, data);
		if (data !== 32'h0)
			report_mismatch("prdata", 32'h0, data);
		apb_read(`MMU_REG_STAGE_PPN, data);
		if (data !== 32'h0)
			report_mismatch("prdata", 32'h0, data);
		end_test("reset_state", errs);
	endtask

	task automatic fill_and_translate();
		int errs;
		logic [11:0] off_a;
		logic [11:0] off_b;
		errs = errors;
		rnd = lcg_next(rnd);
		off_a = rnd[31:20];
		off_b = rnd[19:8];
		tlb_fill(0, 20'h12345, 20'hABCDE, 1'b1, 3'b111);
		tlb_fill(1, 20'h00042, 20'h00777, 1'b1, 3'b111);
		// Back to back requests get one response each
		drive_req(1'b1, {20'h12345, off_a}, mmu_pkg::OM_MACHINE, 1'b0, 1'b0);
		@(negedge clk);
		check_xlate(1'b0, (32'h000A_BCDE << `MMU_PAGE_SHIFT) + 32'(off_a));
		drive_req(1'b1, {20'h00042, off_b}, mmu_pkg::OM_MACHINE, 1'b0, 1'b0);
		@(negedge clk);
		check_xlate(1'b0, (32'h0000_0777 << `MMU_PAGE_SHIFT) + 32'(off_b));
		// Never filled
		drive_req(1'b1, {20'h99999, off_a}, mmu_pkg::OM_MACHINE, 1'b0, 1'b0);
		@(negedge clk);
		check_xlate(1'b1, 32'h0);
		req_valid = 1'b0;
		@(negedge clk);
		if (rsp_valid !== 1'b0)
			report_mismatch("rsp_valid", 32'h0, 32'(rsp_valid));
		end_test("fill_translate", errs);
	endtask

	task automatic privilege_rule();
		int errs;
		mmu_pkg::op_mode_t m;
		logic f;
		logic w;
		logic pu;
		mmu_pkg::rwx_t pg;
		logic [2:0] ridx;
		logic [11:0] rg;
		mmu_pkg::vpn_t vpn;
		logic [11:0] off;
		logic exp_err;
		errs = errors;
		for (int n = 0; n < 64; n++)
		begin
			rnd = lcg_next(rnd);
			m = rnd[31:30];
			f = rnd[29];
			w = rnd[28];
			pg = rnd[27:25];
			pu = rnd[24];
			ridx = rnd[23:21];
			off = rnd[11:0];
			rnd = lcg_next(rnd);
			rg = rnd[31:20];
			// Top page bits pick the region
			vpn = {ridx, rnd[18:2]};
			apb_write(`MMU_REG_REGION0 + {3'b000, ridx, 2'b00}, {20'h0, rg});
			tlb_fill(0, vpn, vpn ^ 20'h5A5A5, pu, pg);
			lookup({vpn, off}, m, f, w);
			exp_err = priv_model(m, f, w, pg, pu, rg);
			check_xlate(1'b0, {vpn ^ 20'h5A5A5, off});
			if (priv_err !== exp_err)
			begin
				$display("Case %0d: om %0d id %b we %b page rwx %b u %b region 0x%h",
					n, m, f, w, pg, pu, rg);
				report_mismatch("priv_err", 32'(exp_err), 32'(priv_err));
			end
		end
		end_test("priv_rule", errs);
	endtask

	task automatic lowest_slot_priority();
		int errs;
		errs = errors;
		tlb_flush();
		// Lower slot wins for a page held twice
		tlb_fill(3, 20'h2468A, 20'h11111, 1'b1, 3'b111);
		tlb_fill(1, 20'h2468A, 20'h22222, 1'b1, 3'b111);
		lookup({20'h2468A, 12'h0F0}, mmu_pkg::OM_MACHINE, 1'b0, 1'b0);
		check_xlate(1'b0, 32'h2222_20F0);
		end_test("priority", errs);
	endtask

	task automatic flush_and_slverr();
		int errs;
		logic [31:0] data;
		errs = errors;
		tlb_fill(2, 20'h0BEEF, 20'h0CAFE, 1'b1, 3'b111);
		lookup({20'h0BEEF, 12'h004}, mmu_pkg::OM_MACHINE, 1'b0, 1'b0);
		check_xlate(1'b0, 32'h0CAF_E004);
		tlb_flush();
		lookup({20'h0BEEF, 12'h004}, mmu_pkg::OM_MACHINE, 1'b0, 1'b0);
		check_xlate(1'b1, 32'h0);
		// Left over from the priority test
		lookup({20'h2468A, 12'h0F0}, mmu_pkg::OM_MACHINE, 1'b0, 1'b0);
		check_xlate(1'b1, 32'h0);
		// Outside the register map
		apb_write(8'h40, 32'h0000_0001);
		if (apb_err !== 1'b1)
			report_mismatch("pslverr", 32'h1, 32'(apb_err));
		apb_read(8'h40, data);
		if (apb_err !== 1'b1)
			report_mismatch("pslverr", 32'h1, 32'(apb_err));
		// Mapped offsets stay quiet
		apb_read(`MMU_REG_STAGE_VPN, data);
		if (apb_err !== 1'b0)
			report_mismatch("pslverr", 32'h0, 32'(apb_err));
		apb_write(`MMU_REG_REGION0, 32'h0000_0FFF);
		if (apb_err !== 1'b0)
			report_mismatch("pslverr", 32'h0, 32'(apb_err));
		apb_write(`MMU_REG_FLUSH, 32'h0);
		if (apb_err !== 1'b0)
			report_mismatch("pslverr", 32'h0, 32'(apb_err));
		end_test("flush_slverr", errs);
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'h00;
		pwdata = 32'h0;
		req_valid = 1'b0;
		vaddr = 32'h0;
		om = mmu_pkg::OM_USER;
		id = 1'b0;
		we = 1'b0;
		apb_phase = mmu_pkg::APB_IDLE;
		apb_err = 1'b0;
		rnd = 32'hc23b;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		cycles = 0;
		// Two rising edges in reset
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		reset_defaults();
		fill_and_translate();
		privilege_rule();
		lowest_slot_priority();
		flush_and_slverr();
		$display("Summary: %0d tests, %0d with mismatches, %0d mismatches in all",
			tests, failed_tests, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+common
common/mmu_pkg.sv
common/tlb_fill_if.sv
hdl/mmu_attr_check.sv
tlb/tlb_entry_slot.sv
tlb/tlb_hit_select.sv
hdl/mmu_apb_regs.sv
hdl/mmu_xlate_top.sv
tests/mmu_xlate_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the MMU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f list.f --top-module mmu_xlate_tb \
	-Mdir obj_dir -o mmu_xlate_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/mmu_xlate_sim)
status=$?
echo "$sim_out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "No errors" <<< "$sim_out"; then
	exit 0
fi
exit 1
